/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

    // reorder buffer
    localparam int ROB_DEPTH = 8;
    localparam int ROB_IDX_W = 3;
    localparam int ROB_CNT_W = ROB_IDX_W + 1;

    // fetch side instruction buffer
    localparam int IBUF_DEPTH = 4;
    localparam int IBUF_PTR_W = $clog2(IBUF_DEPTH);
    localparam int IBUF_CNT_W = IBUF_PTR_W + 1;

    // register files, arch and physical
    localparam int NUM_AREGS = 8;
    localparam int NUM_PREGS = 16;
    localparam int AREG_W    = $clog2(NUM_AREGS);
    localparam int PREG_W    = $clog2(NUM_PREGS);

    typedef logic [AREG_W-1:0]    areg_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // recover lasts one cycle after a squash
    typedef enum logic {
        ROB_RUN,
        ROB_RECOVER
    } rob_state_e;

endpackage

`default_nettype wire

/* design/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int INST_W = 16;
    localparam int OPC_W  = 4;

    // field positions inside the instruction word, bits 2:0 unused
    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 9;
    localparam int RS1_LSB = 6;
    localparam int RS2_LSB = 3;

    typedef logic [INST_W-1:0] inst_t;

    // any other opcode value is illegal
    typedef enum logic [OPC_W-1:0] {
        OPC_NOP    = 4'd0,
        OPC_ALU    = 4'd1,
        OPC_LOAD   = 4'd2,
        OPC_STORE  = 4'd3,
        OPC_BRANCH = 4'd4
    } opcode_e;

    typedef enum logic [2:0] {
        UOP_NOP,
        UOP_ALU,
        UOP_LOAD,
        UOP_STORE,
        UOP_BRANCH,
        UOP_ILLEGAL
    } uop_class_e;

endpackage

`default_nettype wire

/* design/inst_buffer.sv */
`default_nettype none

module inst_buffer (
    input  wire                 clk,
    input  wire                 i_arst_n,
    input  wire                 i_flush,
    input  wire                 i_enq_vld,
    input  wire isa_pkg::inst_t i_enq_inst,
    output logic                o_can_enq,
    output logic                o_deq_vld,
    output isa_pkg::inst_t      o_deq_inst,
    input  wire                 i_deq_rdy
);
    import core_pkg::*;
    import isa_pkg::*;

    inst_t                 mem [IBUF_DEPTH];
    logic [IBUF_PTR_W-1:0] wr_ptr;
    logic [IBUF_PTR_W-1:0] rd_ptr;
    logic [IBUF_CNT_W-1:0] count;
    logic                  enq_fire;
    logic                  deq_fire;

    assign o_can_enq  = (count != IBUF_CNT_W'(IBUF_DEPTH));
    assign o_deq_vld  = (count != '0);
    assign o_deq_inst = mem[rd_ptr];
    assign enq_fire   = i_enq_vld && o_can_enq;
    assign deq_fire   = o_deq_vld && i_deq_rdy;

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + IBUF_CNT_W'(enq_fire) - IBUF_CNT_W'(deq_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= i_enq_inst;
        end
    end

    // count stays within the depth
    a_no_enq_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        count <= IBUF_CNT_W'(IBUF_DEPTH));

    // write pointer leads the read pointer by the count
    a_no_deq_empty: assert property (@(posedge clk) disable iff (!i_arst_n)
        wr_ptr == rd_ptr + IBUF_PTR_W'(count));

endmodule

`default_nettype wire

/* design/decode.sv */
`default_nettype none

module decode (
    input  wire                 clk,
    input  wire                 i_arst_n,
    input  wire                 i_flush,
    input  wire                 i_inst_vld,
    input  wire isa_pkg::inst_t i_inst,
    output logic                o_inst_rdy,
    output logic                o_vld,
    output isa_pkg::uop_class_e o_class,
    output core_pkg::areg_t     o_rd,
    output core_pkg::areg_t     o_rs1,
    output core_pkg::areg_t     o_rs2,
    output logic                o_wr_rd,
    output logic                o_illegal,
    input  wire                 i_rdy
);
    import core_pkg::*;
    import isa_pkg::*;

    uop_class_e cls_d;
    logic       wr_d;
    logic       take;

    // one entry stage, refills in the cycle it drains
    assign o_inst_rdy = !o_vld || i_rdy;
    assign take       = i_inst_vld && o_inst_rdy;

    // only alu and load produce a result in rd
    always_comb begin
        case (opcode_e'(i_inst[OPC_LSB +: OPC_W]))
            OPC_NOP:    cls_d = UOP_NOP;
            OPC_ALU:    cls_d = UOP_ALU;
            OPC_LOAD:   cls_d = UOP_LOAD;
            OPC_STORE:  cls_d = UOP_STORE;
            OPC_BRANCH: cls_d = UOP_BRANCH;
            default:    cls_d = UOP_ILLEGAL;
        endcase
        wr_d = (cls_d == UOP_ALU) || (cls_d == UOP_LOAD);
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_vld <= 1'b0;
        end else if (i_flush) begin
            o_vld <= 1'b0;
        end else if (take) begin
            o_vld <= 1'b1;
        end else if (i_rdy) begin
            o_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            o_class   <= cls_d;
            o_rd      <= i_inst[RD_LSB +: AREG_W];
            o_rs1     <= i_inst[RS1_LSB +: AREG_W];
            o_rs2     <= i_inst[RS2_LSB +: AREG_W];
            o_wr_rd   <= wr_d;
            o_illegal <= (cls_d == UOP_ILLEGAL);
        end
    end

endmodule

`default_nettype wire

/* design/rename.sv */
`default_nettype none

module rename (
    input  wire                      clk,
    input  wire                      i_arst_n,
    input  wire                      i_squash,
    input  wire                      i_recover,
    input  wire                      i_dec_vld,
    input  wire isa_pkg::uop_class_e i_dec_class,
    input  wire core_pkg::areg_t     i_dec_rd,
    input  wire core_pkg::areg_t     i_dec_rs1,
    input  wire core_pkg::areg_t     i_dec_rs2,
    input  wire                      i_dec_wr_rd,
    input  wire                      i_dec_illegal,
    output logic                     o_dec_rdy,
    input  wire                      i_disp_fire,
    output logic                     o_disp_vld,
    output isa_pkg::uop_class_e      o_disp_class,
    output core_pkg::preg_t          o_disp_prd,
    output core_pkg::preg_t          o_disp_prs1,
    output core_pkg::preg_t          o_disp_prs2,
    output logic                     o_disp_wr,
    output core_pkg::preg_t          o_disp_old_prd,
    output core_pkg::areg_t          o_disp_ard,
    output logic                     o_disp_illegal,
    input  wire                      i_commit_vld,
    input  wire core_pkg::areg_t     i_commit_ard,
    input  wire core_pkg::preg_t     i_commit_prd,
    input  wire core_pkg::preg_t     i_commit_old_prd
);
    import core_pkg::*;

    preg_t                spec_map [NUM_AREGS];
    preg_t                cmt_map  [NUM_AREGS];
    logic [NUM_PREGS-1:0] free_q;
    logic [NUM_PREGS-1:0] cmt_used;
    preg_t                alloc_prd;
    logic                 take;
    logic                 take_wr;

    // lowest free preg wins
    always_comb begin
        alloc_prd = '0;
        for (int p = NUM_PREGS - 1; p >= 0; p--) begin
            if (free_q[p]) begin
                alloc_prd = preg_t'(p);
            end
        end
    end

    // pregs held by the committed state
    always_comb begin
        cmt_used = '0;
        for (int a = 0; a < NUM_AREGS; a++) begin
            cmt_used[cmt_map[a]] = 1'b1;
        end
    end

    assign o_dec_rdy = (!o_disp_vld || i_disp_fire) && !i_squash && !i_recover
                       && (!i_dec_wr_rd || (|free_q));
    assign take      = i_dec_vld && o_dec_rdy;
    assign take_wr   = take && i_dec_wr_rd;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int a = 0; a < NUM_AREGS; a++) begin
                spec_map[a] <= preg_t'(a);
                cmt_map[a]  <= preg_t'(a);
            end
            free_q <= {{(NUM_PREGS - NUM_AREGS){1'b1}}, {NUM_AREGS{1'b0}}};
        end else begin
            if (i_squash) begin
                spec_map <= cmt_map;
            end else if (take_wr) begin
                spec_map[i_dec_rd] <= alloc_prd;
            end
            if (i_commit_vld) begin
                cmt_map[i_commit_ard] <= i_commit_prd;
            end
            // rebuild from the committed map while the rob is empty
            if (i_recover) begin
                free_q <= ~cmt_used;
            end else begin
                if (take_wr) begin
                    free_q[alloc_prd] <= 1'b0;
                end
                if (i_commit_vld) begin
                    free_q[i_commit_old_prd] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_disp_vld <= 1'b0;
        end else if (i_squash) begin
            o_disp_vld <= 1'b0;
        end else if (take) begin
            o_disp_vld <= 1'b1;
        end else if (i_disp_fire) begin
            o_disp_vld <= 1'b0;
        end
    end

    // sources read the mapping before this instruction's own update
    always_ff @(posedge clk) begin
        if (take) begin
            o_disp_class   <= i_dec_class;
            o_disp_prd     <= i_dec_wr_rd ? alloc_prd : '0;
            o_disp_prs1    <= spec_map[i_dec_rs1];
            o_disp_prs2    <= spec_map[i_dec_rs2];
            o_disp_wr      <= i_dec_wr_rd;
            o_disp_old_prd <= spec_map[i_dec_rd];
            o_disp_ard     <= i_dec_rd;
            o_disp_illegal <= i_dec_illegal;
        end
    end

    // a free preg must never still back committed state
    a_alloc_not_busy: assert property (@(posedge clk) disable iff (!i_arst_n)
        take_wr |-> !cmt_used[alloc_prd]);

endmodule

`default_nettype wire

/* design/rob.sv */
`default_nettype none

module rob (
    input  wire                     clk,
    input  wire                     i_arst_n,
    input  wire                     i_disp_fire,
    output logic                    o_can_alloc,
    output core_pkg::rob_idx_t      o_alloc_idx,
    input  wire core_pkg::areg_t    i_disp_ard,
    input  wire core_pkg::preg_t    i_disp_prd,
    input  wire core_pkg::preg_t    i_disp_old_prd,
    input  wire                     i_disp_wr,
    input  wire                     i_disp_illegal,
    input  wire                     i_wb_vld,
    input  wire core_pkg::rob_idx_t i_wb_rob_idx,
    input  wire                     i_wb_except,
    output logic                    o_commit_vld,
    output core_pkg::rob_idx_t      o_commit_rob_idx,
    output core_pkg::areg_t         o_commit_ard,
    output core_pkg::preg_t         o_commit_prd,
    output logic                    o_commit_wr,
    output core_pkg::preg_t         o_commit_old_prd,
    output logic                    o_squash_vld,
    output core_pkg::rob_idx_t      o_squash_rob_idx,
    output logic                    o_recover
);
    import core_pkg::*;

    logic [ROB_DEPTH-1:0] vld_q;
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] exc_q;
    logic [ROB_DEPTH-1:0] wr_q;
    areg_t                ard_q [ROB_DEPTH];
    preg_t                prd_q [ROB_DEPTH];
    preg_t                old_q [ROB_DEPTH];
    rob_idx_t             head;
    rob_idx_t             tail;
    logic [ROB_CNT_W-1:0] count;
    rob_state_e           state;
    logic                 head_done;

    // head retires or squashes in the cycle it is seen done
    assign head_done        = vld_q[head] && done_q[head];
    assign o_squash_vld     = head_done && exc_q[head];
    assign o_commit_vld     = head_done && !exc_q[head];
    assign o_commit_wr      = o_commit_vld && wr_q[head];
    assign o_commit_rob_idx = head;
    assign o_commit_ard     = ard_q[head];
    assign o_commit_prd     = prd_q[head];
    assign o_commit_old_prd = old_q[head];
    assign o_squash_rob_idx = head;
    assign o_alloc_idx      = tail;
    assign o_recover        = (state == ROB_RECOVER);
    assign o_can_alloc      = (state == ROB_RUN) && !o_squash_vld
                              && (count != ROB_CNT_W'(ROB_DEPTH));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vld_q  <= '0;
            done_q <= '0;
            exc_q  <= '0;
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            state  <= ROB_RUN;
        end else if (o_squash_vld) begin
            // drop everything, tail restarts at the squashed slot
            vld_q <= '0;
            tail  <= head;
            count <= '0;
            state <= ROB_RECOVER;
        end else begin
            state <= ROB_RUN;
            if (i_wb_vld) begin
                done_q[i_wb_rob_idx] <= 1'b1;
                exc_q[i_wb_rob_idx]  <= i_wb_except;
            end
            // illegal ops arrive already done and excepting
            if (i_disp_fire) begin
                vld_q[tail]  <= 1'b1;
                done_q[tail] <= i_disp_illegal;
                exc_q[tail]  <= i_disp_illegal;
                tail         <= tail + 1'b1;
            end
            if (o_commit_vld) begin
                vld_q[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            count <= count + ROB_CNT_W'(i_disp_fire) - ROB_CNT_W'(o_commit_vld);
        end
    end

    always_ff @(posedge clk) begin
        if (i_disp_fire) begin
            ard_q[tail] <= i_disp_ard;
            prd_q[tail] <= i_disp_prd;
            old_q[tail] <= i_disp_old_prd;
            wr_q[tail]  <= i_disp_wr;
        end
    end

    // execution stage only completes live entries
    a_wb_valid: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_wb_vld |-> vld_q[i_wb_rob_idx]);

    a_commit_nonempty: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_commit_vld |-> (count != '0) && (state == ROB_RUN));

endmodule

`default_nettype wire

/* design/ctrl_block.sv */
`default_nettype none

// buffer, decode and rename feed dispatch, the rob drives commit and squash
module ctrl_block (
    input  wire                     clk,
    input  wire                     i_arst_n,
    input  wire                     i_inst_vld,
    input  wire isa_pkg::inst_t     i_inst,
    output logic                    o_stall,
    output logic                    o_disp_vld,
    output isa_pkg::uop_class_e     o_disp_class,
    output core_pkg::preg_t         o_disp_prd,
    output core_pkg::preg_t         o_disp_prs1,
    output core_pkg::preg_t         o_disp_prs2,
    output core_pkg::rob_idx_t      o_disp_rob_idx,
    input  wire                     i_disp_rdy,
    input  wire                     i_wb_vld,
    input  wire core_pkg::rob_idx_t i_wb_rob_idx,
    input  wire                     i_wb_except,
    output logic                    o_commit_vld,
    output core_pkg::rob_idx_t      o_commit_rob_idx,
    output core_pkg::areg_t         o_commit_ard,
    output core_pkg::preg_t         o_commit_prd,
    output logic                    o_squash_vld,
    output core_pkg::rob_idx_t      o_squash_rob_idx
);
    import core_pkg::*;
    import isa_pkg::*;

    logic       can_enq;
    logic       ib_vld;
    inst_t      ib_inst;
    logic       ib_rdy;
    logic       dec_vld;
    uop_class_e dec_class;
    areg_t      dec_rd;
    areg_t      dec_rs1;
    areg_t      dec_rs2;
    logic       dec_wr_rd;
    logic       dec_illegal;
    logic       dec_rdy;
    logic       disp_fire;
    logic       rob_can_alloc;
    logic       disp_wr;
    preg_t      disp_old_prd;
    areg_t      disp_ard;
    logic       disp_illegal;
    logic       commit_wr;
    preg_t      commit_old_prd;
    logic       recover;

    assign o_stall   = !can_enq;
    // one dispatch per cycle, rename and rob see the same strobe
    assign disp_fire = o_disp_vld && i_disp_rdy && rob_can_alloc;

    inst_buffer u_inst_buffer (
        .clk        (clk),          .i_arst_n   (i_arst_n),
        .i_flush    (o_squash_vld),
        .i_enq_vld  (i_inst_vld),   .i_enq_inst (i_inst),
        .o_can_enq  (can_enq),
        .o_deq_vld  (ib_vld),       .o_deq_inst (ib_inst),
        .i_deq_rdy  (ib_rdy)
    );

    decode u_decode (
        .clk        (clk),          .i_arst_n   (i_arst_n),
        .i_flush    (o_squash_vld),
        .i_inst_vld (ib_vld),       .i_inst     (ib_inst),
        .o_inst_rdy (ib_rdy),
        .o_vld      (dec_vld),      .o_class    (dec_class),
        .o_rd       (dec_rd),       .o_rs1      (dec_rs1),
        .o_rs2      (dec_rs2),      .o_wr_rd    (dec_wr_rd),
        .o_illegal  (dec_illegal),  .i_rdy      (dec_rdy)
    );

    rename u_rename (
        .clk              (clk),              .i_arst_n       (i_arst_n),
        .i_squash         (o_squash_vld),     .i_recover      (recover),
        .i_dec_vld        (dec_vld),          .i_dec_class    (dec_class),
        .i_dec_rd         (dec_rd),           .i_dec_rs1      (dec_rs1),
        .i_dec_rs2        (dec_rs2),          .i_dec_wr_rd    (dec_wr_rd),
        .i_dec_illegal    (dec_illegal),      .o_dec_rdy      (dec_rdy),
        .i_disp_fire      (disp_fire),        .o_disp_vld     (o_disp_vld),
        .o_disp_class     (o_disp_class),     .o_disp_prd     (o_disp_prd),
        .o_disp_prs1      (o_disp_prs1),      .o_disp_prs2    (o_disp_prs2),
        .o_disp_wr        (disp_wr),          .o_disp_old_prd (disp_old_prd),
        .o_disp_ard       (disp_ard),         .o_disp_illegal (disp_illegal),
        .i_commit_vld     (commit_wr),        .i_commit_ard   (o_commit_ard),
        .i_commit_prd     (o_commit_prd),     .i_commit_old_prd (commit_old_prd)
    );

    rob u_rob (
        .clk              (clk),              .i_arst_n       (i_arst_n),
        .i_disp_fire      (disp_fire),        .o_can_alloc    (rob_can_alloc),
        .o_alloc_idx      (o_disp_rob_idx),   .i_disp_ard     (disp_ard),
        .i_disp_prd       (o_disp_prd),       .i_disp_old_prd (disp_old_prd),
        .i_disp_wr        (disp_wr),          .i_disp_illegal (disp_illegal),
        .i_wb_vld         (i_wb_vld),         .i_wb_rob_idx   (i_wb_rob_idx),
        .i_wb_except      (i_wb_except),      .o_commit_vld   (o_commit_vld),
        .o_commit_rob_idx (o_commit_rob_idx), .o_commit_ard   (o_commit_ard),
        .o_commit_prd     (o_commit_prd),     .o_commit_wr    (commit_wr),
        .o_commit_old_prd (commit_old_prd),   .o_squash_vld   (o_squash_vld),
        .o_squash_rob_idx (o_squash_rob_idx), .o_recover      (recover)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_arst_n
);
    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // reset held for 16 rising edges
    initial begin
        o_arst_n = 1'b0;
        repeat (16) @(posedge o_clk);
        #1 o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/tb_ctrl_block.sv */
`default_nettype none

module tb_ctrl_block;
    import core_pkg::*;
    import isa_pkg::*;

    typedef struct packed {
        uop_class_e cls;
        preg_t      prd;
        preg_t      prs1;
        preg_t      prs2;
        areg_t      ard;
        preg_t      old;
        logic       wr;
        logic       rd1;
        logic       rd2;
        logic       illegal;
        logic       exc;
        logic [7:0] delay;
    } disp_t;

    typedef struct packed {
        rob_idx_t idx;
        areg_t    ard;
        preg_t    prd;
        preg_t    old;
        logic     wr;
        logic     exc;
        logic     done;
    } rob_ent_t;

    typedef struct packed {
        rob_idx_t    idx;
        logic [31:0] ready;
        logic        exc;
    } wb_ent_t;

    logic clk, arst_n;
    logic i_inst_vld, i_disp_rdy, i_wb_vld, i_wb_except;
    inst_t i_inst;
    rob_idx_t i_wb_rob_idx;
    logic o_stall, o_disp_vld, o_commit_vld, o_squash_vld;
    uop_class_e o_disp_class;
    preg_t o_disp_prd, o_disp_prs1, o_disp_prs2, o_commit_prd;
    rob_idx_t o_disp_rob_idx, o_commit_rob_idx, o_squash_rob_idx;
    areg_t o_commit_ard;

    // stimulus table and model state
    inst_t tbl_inst[$];
    int tbl_hold[$];
    int tbl_delay[$];
    bit tbl_exc[$];
    bit tbl_drain[$];
    int buf_q[$];
    rob_ent_t rob_q[$];
    wb_ent_t wb_q[$];
    preg_t spec_map [NUM_AREGS];
    preg_t cmt_map [NUM_AREGS];
    logic [NUM_PREGS-1:0] free_set;
    disp_t disp_exp, ev_fire_ent;
    logic disp_has, recover_now;
    logic ev_fire, ev_commit, ev_squash, ev_recover, ev_wb, ev_wb_exc;
    logic ev_ren, ev_dec, ev_enq;
    rob_idx_t ev_wb_idx, tail_idx;
    int hold_left, cyc, limit, next_row, n_squash, dec_row, ev_enq_row;
    bit seen_stall, finished, exp_sq, exp_cm, exp_stall, drained;
    integer seed;

    tb_clock_gen u_clock_gen (.o_clk(clk), .o_arst_n(arst_n));

    ctrl_block i_ctrl_block (
        .clk(clk), .i_arst_n(arst_n), .i_inst_vld(i_inst_vld), .i_inst(i_inst),
        .o_stall(o_stall), .o_disp_vld(o_disp_vld), .o_disp_class(o_disp_class),
        .o_disp_prd(o_disp_prd), .o_disp_prs1(o_disp_prs1), .o_disp_prs2(o_disp_prs2),
        .o_disp_rob_idx(o_disp_rob_idx), .i_disp_rdy(i_disp_rdy), .i_wb_vld(i_wb_vld),
        .i_wb_rob_idx(i_wb_rob_idx), .i_wb_except(i_wb_except),
        .o_commit_vld(o_commit_vld), .o_commit_rob_idx(o_commit_rob_idx),
        .o_commit_ard(o_commit_ard), .o_commit_prd(o_commit_prd),
        .o_squash_vld(o_squash_vld), .o_squash_rob_idx(o_squash_rob_idx)
    );

    task automatic report_value(string name, int got, int exp);
        $display("error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_text(string what);
        $display("error at time %0t: %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic inst_t encode(logic [3:0] opc, areg_t rd, areg_t rs1, areg_t rs2);
        return {opc, rd, rs1, rs2, 3'b000};
    endfunction

    // alu and load are the only classes with a result
    function automatic bit writes_rd(inst_t inst);
        return (inst[15:12] == 4'd1) || (inst[15:12] == 4'd2);
    endfunction

    task automatic add_row(logic [3:0] opc, areg_t rd, areg_t rs1, areg_t rs2,
                           int hold, int delay, bit exc, bit drain);
        tbl_inst.push_back(encode(opc, rd, rs1, rs2));
        tbl_hold.push_back(hold);
        tbl_delay.push_back(delay);
        tbl_exc.push_back(exc);
        tbl_drain.push_back(drain);
    endtask

    // reference rename of one row, lowest free preg first
    task automatic rename_row(int r);
        logic [3:0] opc;
        areg_t rd;
        opc = tbl_inst[r][15:12];
        rd = tbl_inst[r][11:9];
        disp_exp = '0;
        case (opc)
            4'd0: disp_exp.cls = UOP_NOP;
            4'd1: disp_exp.cls = UOP_ALU;
            4'd2: disp_exp.cls = UOP_LOAD;
            4'd3: disp_exp.cls = UOP_STORE;
            4'd4: disp_exp.cls = UOP_BRANCH;
            default: disp_exp.cls = UOP_ILLEGAL;
        endcase
        disp_exp.illegal = (opc > 4'd4);
        disp_exp.wr = writes_rd(tbl_inst[r]);
        disp_exp.rd1 = (opc >= 4'd1) && (opc <= 4'd4);
        disp_exp.rd2 = (opc == 4'd1) || (opc == 4'd3) || (opc == 4'd4);
        disp_exp.prs1 = spec_map[tbl_inst[r][8:6]];
        disp_exp.prs2 = spec_map[tbl_inst[r][5:3]];
        disp_exp.ard = rd;
        disp_exp.old = spec_map[rd];
        disp_exp.exc = tbl_exc[r];
        disp_exp.delay = 8'(tbl_delay[r]);
        if (disp_exp.wr) begin
            for (int p = NUM_PREGS - 1; p >= 0; p--) begin
                if (free_set[p]) begin
                    disp_exp.prd = preg_t'(p);
                end
            end
            free_set[disp_exp.prd] = 1'b0;
            spec_map[rd] = disp_exp.prd;
        end
        hold_left = tbl_hold[r];
    endtask

    // model state changes caused by the edge that just passed
    task automatic apply_edge();
        rob_ent_t ent;
        logic [NUM_PREGS-1:0] used;
        // buffer, decode and dispatch register move together
        if (ev_squash) begin
            buf_q.delete();
            dec_row = -1;
        end else begin
            if (ev_ren) begin
                rename_row(dec_row);
                disp_has = 1'b1;
                dec_row = -1;
            end
            if (ev_dec) begin
                dec_row = buf_q.pop_front();
            end
            if (ev_enq) begin
                buf_q.push_back(ev_enq_row);
            end
        end
        if (ev_commit) begin
            ent = rob_q.pop_front();
            if (ent.wr) begin
                cmt_map[ent.ard] = ent.prd;
                free_set[ent.old] = 1'b1;
            end
        end
        if (ev_fire) begin
            ent = '{tail_idx, ev_fire_ent.ard, ev_fire_ent.prd, ev_fire_ent.old,
                    ev_fire_ent.wr, ev_fire_ent.illegal, ev_fire_ent.illegal};
            rob_q.push_back(ent);
            if (!ev_fire_ent.illegal) begin
                wb_q.push_back('{tail_idx, 32'(cyc + int'(ev_fire_ent.delay)
                                 + ((($random(seed)) & 32'h7fffffff) % 3)),
                                 ev_fire_ent.exc});
            end
            tail_idx = tail_idx + 1'b1;
        end
        if (ev_wb) begin
            foreach (rob_q[i]) begin
                if (rob_q[i].idx == ev_wb_idx) begin
                    rob_q[i].done = 1'b1;
                    rob_q[i].exc = ev_wb_exc;
                end
            end
        end
        recover_now = ev_squash;
        if (ev_squash) begin
            tail_idx = rob_q[0].idx;
            rob_q.delete();
            wb_q.delete();
            spec_map = cmt_map;
            n_squash++;
        end
        if (ev_recover) begin
            used = '0;
            for (int a = 0; a < NUM_AREGS; a++) begin
                used[cmt_map[a]] = 1'b1;
            end
            free_set = ~used;
        end
    endtask

    task automatic check_outputs();
        exp_sq = (rob_q.size() > 0) && rob_q[0].done && rob_q[0].exc;
        exp_cm = (rob_q.size() > 0) && rob_q[0].done && !rob_q[0].exc;
        exp_stall = (buf_q.size() == IBUF_DEPTH);
        assert (o_squash_vld == exp_sq) else report_value("o_squash_vld", o_squash_vld, exp_sq);
        assert (o_commit_vld == exp_cm) else report_value("o_commit_vld", o_commit_vld, exp_cm);
        assert (o_disp_vld == disp_has) else report_value("o_disp_vld", o_disp_vld, disp_has);
        assert (o_stall == exp_stall) else report_value("o_stall", o_stall, exp_stall);
        if (exp_sq) begin
            assert (o_squash_rob_idx == rob_q[0].idx)
                else report_value("o_squash_rob_idx", o_squash_rob_idx, rob_q[0].idx);
        end
        if (exp_cm) begin
            assert (o_commit_rob_idx == rob_q[0].idx)
                else report_value("o_commit_rob_idx", o_commit_rob_idx, rob_q[0].idx);
            assert (o_commit_ard == rob_q[0].ard)
                else report_value("o_commit_ard", o_commit_ard, rob_q[0].ard);
            assert (o_commit_prd == rob_q[0].prd)
                else report_value("o_commit_prd", o_commit_prd, rob_q[0].prd);
        end
        if (disp_has) begin
            assert (o_disp_class == disp_exp.cls)
                else report_value("o_disp_class", o_disp_class, disp_exp.cls);
            assert (o_disp_rob_idx == tail_idx)
                else report_value("o_disp_rob_idx", o_disp_rob_idx, tail_idx);
            assert (!disp_exp.wr || o_disp_prd == disp_exp.prd)
                else report_value("o_disp_prd", o_disp_prd, disp_exp.prd);
            assert (!disp_exp.rd1 || o_disp_prs1 == disp_exp.prs1)
                else report_value("o_disp_prs1", o_disp_prs1, disp_exp.prs1);
            assert (!disp_exp.rd2 || o_disp_prs2 == disp_exp.prs2)
                else report_value("o_disp_prs2", o_disp_prs2, disp_exp.prs2);
        end
    endtask

    // drive this cycle's inputs and note what the next edge will do
    task automatic drive_inputs();
        int cand[$];
        int pick;
        i_disp_rdy = !(disp_has && hold_left > 0);
        if (disp_has && hold_left > 0) begin
            hold_left--;
        end
        drained = (buf_q.size() == 0) && (dec_row < 0) && !disp_has && (rob_q.size() == 0)
                  && !recover_now;
        i_inst_vld = 1'b0;
        ev_enq = 1'b0;
        if (next_row < tbl_inst.size() && !o_stall && !exp_sq
            && (!tbl_drain[next_row] || drained)) begin
            i_inst_vld = 1'b1;
            i_inst = tbl_inst[next_row];
            ev_enq = 1'b1;
            ev_enq_row = next_row;
            next_row++;
        end
        i_wb_vld = 1'b0;
        foreach (wb_q[i]) begin
            if (int'(wb_q[i].ready) <= cyc) begin
                cand.push_back(i);
            end
        end
        if (!exp_sq && cand.size() > 0) begin
            pick = cand[(($random(seed)) & 32'h7fffffff) % cand.size()];
            i_wb_vld = 1'b1;
            i_wb_rob_idx = wb_q[pick].idx;
            i_wb_except = wb_q[pick].exc;
            wb_q.delete(pick);
        end
        ev_wb = i_wb_vld;
        ev_wb_idx = i_wb_rob_idx;
        ev_wb_exc = i_wb_except;
        ev_fire = disp_has && i_disp_rdy && !exp_sq && !recover_now && (rob_q.size() < ROB_DEPTH);
        ev_fire_ent = disp_exp;
        // rename takes when its register frees and a preg is left for rd
        ev_ren = 1'b0;
        if (dec_row >= 0) begin
            ev_ren = (!disp_has || ev_fire) && !exp_sq && !recover_now
                     && (!writes_rd(tbl_inst[dec_row]) || free_set != '0);
        end
        ev_dec = (buf_q.size() > 0) && ((dec_row < 0) || ev_ren);
        ev_commit = exp_cm;
        ev_squash = exp_sq;
        ev_recover = recover_now;
        if (ev_fire || exp_sq) begin
            disp_has = 1'b0;
        end
        seen_stall = seen_stall || o_stall;
    endtask

    initial begin
        seed = 32'hb04b397e;
        i_inst_vld = 1'b0;
        i_inst = '0;
        i_disp_rdy = 1'b1;
        i_wb_vld = 1'b0;
        i_wb_rob_idx = '0;
        i_wb_except = 1'b0;
        // opcode rd rs1 rs2, hold, wb delay, except, wait for drain
        add_row(4'd1, 3'd1, 3'd2, 3'd3, 0, 3, 0, 0);
        add_row(4'd2, 3'd2, 3'd1, 3'd0, 0, 1, 0, 0);
        add_row(4'd1, 3'd3, 3'd1, 3'd2, 0, 5, 0, 0);
        add_row(4'd3, 3'd0, 3'd3, 3'd2, 0, 2, 0, 0);
        add_row(4'd1, 3'd1, 3'd1, 3'd1, 12, 2, 0, 0);
        for (int k = 0; k < 4; k++) begin
            add_row(4'd1, areg_t'(k + 2), areg_t'(k), areg_t'(k + 1), 0, 1, 0, 0);
        end
        add_row(4'd4, 3'd0, 3'd1, 3'd2, 0, 1, 0, 0);
        add_row(4'd1, 3'd4, 3'd4, 3'd3, 0, 20, 0, 0);
        for (int k = 0; k < 7; k++) begin
            add_row(4'd1, areg_t'(k), areg_t'(k + 1), 3'd4, 0, 1, 0, 0);
        end
        add_row(4'd1, 3'd5, 3'd5, 3'd6, 0, 2, 1, 0);
        add_row(4'd1, 3'd6, 3'd5, 3'd1, 0, 1, 0, 0);
        add_row(4'd1, 3'd1, 3'd5, 3'd6, 0, 2, 0, 1);
        add_row(4'hf, 3'd2, 3'd1, 3'd1, 0, 1, 0, 0);
        add_row(4'd1, 3'd2, 3'd1, 3'd3, 0, 1, 0, 0);
        add_row(4'd1, 3'd3, 3'd1, 3'd2, 0, 3, 0, 1);
        add_row(4'd2, 3'd7, 3'd3, 3'd0, 0, 1, 0, 0);
        limit = tbl_inst.size() * 40 + 200;
        for (int a = 0; a < NUM_AREGS; a++) begin
            spec_map[a] = preg_t'(a);
            cmt_map[a] = preg_t'(a);
        end
        free_set = 16'hff00;
        disp_has = 1'b0;
        recover_now = 1'b0;
        {ev_fire, ev_commit, ev_squash, ev_recover, ev_wb} = '0;
        ev_ren = 1'b0;
        ev_dec = 1'b0;
        ev_enq = 1'b0;
        dec_row = -1;
        tail_idx = '0;
        cyc = 0;
        next_row = 0;
        n_squash = 0;
        seen_stall = 0;
        finished = 0;
        repeat (4) @(posedge clk);
        #1;
        assert (!o_disp_vld && !o_commit_vld && !o_squash_vld && !o_stall)
            else report_text("outputs not idle during reset");
        wait (arst_n === 1'b1);
        while (!finished) begin
            @(posedge clk);
            #1;
            cyc++;
            if (cyc > limit) begin
                report_text("timeout before the table completed");
            end
            apply_edge();
            check_outputs();
            drive_inputs();
            finished = (next_row == tbl_inst.size()) && drained && !ev_fire;
        end
        if (!seen_stall || n_squash != 2) begin
            report_text("stall or squash count not as expected");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* ctrl_block.f */
design/core_pkg.sv
design/isa_pkg.sv
design/inst_buffer.sv
design/decode.sv
design/rename.sv
design/rob.sv
design/ctrl_block.sv
verif/tb_clock_gen.sv
verif/tb_ctrl_block.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ctrl_block testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_ctrl_block -f ctrl_block.f -o sim_ctrl_block
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output="$(./obj_dir/sim_ctrl_block 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1
